//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_mci_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TB FAILED
PASS_MSG  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
+incdir+src
src/mci_pkg.sv
src/mci_sub_decode.sv
src/mci_reg_block.sv
src/mci_mbox_mem.sv
src/mci_sram.sv
src/mci_top.sv
tb/tb_clk_gen.sv
tb/tb_mci_top.sv

//--- src/mci_mbox_mem.sv
`default_nettype none
`include "mci_settings.svh"

module mci_mbox_mem (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dv,
    input  mci_pkg::addr_t addr,
    input  mci_pkg::data_t wdata,
    input  mci_pkg::strb_t wstrb,
    input  logic           write,
    output mci_pkg::data_t rdata,
    output logic           hold,
    output logic           error
);
    import mci_pkg::*;

    // Both mailboxes share one size
    localparam int WORDS = `MCI_MBOX0_SIZE / 4;
    localparam int IDX_W = $clog2(WORDS);

    data_t            mem [WORDS];
    logic [IDX_W-1:0] idx;

    // Word offset within the mailbox window
    assign idx = addr[IDX_W+1:2];

    // Zero wait, never errors
    assign rdata = mem[idx];
    assign hold  = 1'b0;
    assign error = 1'b0;

    // Mailbox contents start cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (dv && write) begin
            mem[idx] <= strb_merge(mem[idx], wdata, wstrb);
        end
    end

endmodule

`default_nettype wire

//--- src/mci_pkg.sv
`default_nettype none
`include "mci_settings.svh"

package mci_pkg;

    // Byte address, data word, byte strobes and AXI user
    typedef logic [`MCI_ADDR_W-1:0]   addr_t;
    typedef logic [`MCI_DATA_W-1:0]   data_t;
    typedef logic [`MCI_DATA_W/8-1:0] strb_t;
    typedef logic [`MCI_USER_W-1:0]   user_t;

    // One mailbox's list of valid users
    typedef user_t [`MCI_MBOX_USER_N-1:0] user_list_t;

    // SRAM wait-state FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } sram_state_e;

    // Replace the strobed bytes of cur with those of nxt
    function automatic data_t strb_merge(input data_t cur, input data_t nxt, input strb_t strb);
        data_t res;
        res = cur;
        for (int b = 0; b < `MCI_DATA_W/8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = nxt[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- src/mci_reg_block.sv
`default_nettype none
`include "mci_settings.svh"

module mci_reg_block (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dv,
    input  mci_pkg::addr_t      addr,
    input  mci_pkg::data_t      wdata,
    input  mci_pkg::strb_t      wstrb,
    input  logic                write,
    input  logic                priv,
    output mci_pkg::data_t      rdata,
    output logic                hold,
    output logic                error,
    output mci_pkg::user_list_t mbox0_users,
    output mci_pkg::user_list_t mbox1_users
);
    import mci_pkg::*;

    localparam int N = `MCI_MBOX_USER_N;

    data_t        scratch;
    logic [7:0]   off;
    logic         sel_scratch;
    logic [N-1:0] sel0;
    logic [N-1:0] sel1;
    logic         list_hit;
    logic         unmapped;
    logic         refused;
    logic         wr_en;

    ////////////////////
    // Offset decode
    ////////////////////

    // Byte offset in the 256-byte window
    assign off         = addr[7:0];
    assign sel_scratch = (off == 8'h00);

    // List 0 at 0x10, list 1 at 0x30, one word per entry
    for (genvar i = 0; i < N; i++) begin : g_sel
        assign sel0[i] = (off == 8'(8'h10 + 4 * i));
        assign sel1[i] = (off == 8'(8'h30 + 4 * i));
    end

    assign list_hit = (|sel0) | (|sel1);
    assign unmapped = ~sel_scratch & ~list_hit;

    // Only privileged writers may touch a user list
    assign refused  = write & list_hit & ~priv;
    assign error    = dv & (unmapped | refused);
    assign hold     = 1'b0;
    assign wr_en    = dv & write & ~unmapped & ~refused;

    // Read mux from current contents
    always_comb begin
        rdata = '0;
        if (sel_scratch) begin
            rdata = scratch;
        end
        for (int i = 0; i < N; i++) begin
            if (sel0[i]) begin
                rdata = mbox0_users[i];
            end
            if (sel1[i]) begin
                rdata = mbox1_users[i];
            end
        end
    end

    ////////////////////
    // Register storage
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
            for (int i = 0; i < N; i++) begin
                mbox0_users[i] <= `MCI_DEF_MBOX_USER;
                mbox1_users[i] <= `MCI_DEF_MBOX_USER;
            end
        end else if (wr_en) begin
            if (sel_scratch) begin
                scratch <= strb_merge(scratch, wdata, wstrb);
            end
            for (int i = 0; i < N; i++) begin
                if (sel0[i]) begin
                    mbox0_users[i] <= strb_merge(mbox0_users[i], wdata, wstrb);
                end
                if (sel1[i]) begin
                    mbox1_users[i] <= strb_merge(mbox1_users[i], wdata, wstrb);
                end
            end
        end
    end

    // Lists change only on a privileged write
    a_lists_need_priv: assert property (@(posedge clk) disable iff (!rst_n)
        !(dv && write && priv) |=> $stable(mbox0_users) && $stable(mbox1_users));

endmodule

`default_nettype wire

//--- src/mci_settings.svh
`ifndef MCI_SETTINGS_SVH
`define MCI_SETTINGS_SVH

////////////////////
// Bus widths
////////////////////

`define MCI_ADDR_W 32
`define MCI_DATA_W 32
`define MCI_USER_W 32

// Entries in each mailbox valid-user list
`define MCI_MBOX_USER_N 5

////////////////////
// Address map
////////////////////

// Control registers, scratch and user lists
`define MCI_REG_BASE   32'h0000_0000
`define MCI_REG_SIZE   32'h0000_0100

// Two mailboxes of 64 words each
`define MCI_MBOX0_BASE 32'h0000_1000
`define MCI_MBOX0_SIZE 32'h0000_0100
`define MCI_MBOX1_BASE 32'h0000_2000
`define MCI_MBOX1_SIZE 32'h0000_0100

// SRAM end follows from its size in KB
`define MCI_SRAM_BASE  32'h0000_4000
`define MCI_SRAM_SIZE_KB_DEF 1

// User accepted by every mailbox
`define MCI_DEF_MBOX_USER 32'hFFFF_FFFF

`endif

//--- src/mci_sram.sv
`default_nettype none
`include "mci_settings.svh"

module mci_sram #(
    parameter int SRAM_SIZE_KB = `MCI_SRAM_SIZE_KB_DEF
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           dv,
    input  mci_pkg::addr_t addr,
    input  mci_pkg::data_t wdata,
    input  mci_pkg::strb_t wstrb,
    input  logic           write,
    output mci_pkg::data_t rdata,
    output logic           hold,
    output logic           error
);
    import mci_pkg::*;

    localparam int WORDS = SRAM_SIZE_KB * 1024 / 4;
    localparam int IDX_W = $clog2(WORDS);

    data_t            mem [WORDS];
    data_t            rdata_q;
    logic [IDX_W-1:0] idx;
    sram_state_e      state_q;
    sram_state_e      state;

    assign idx = addr[IDX_W+1:2];

    ////////////////////
    // Wait-state FSM
    ////////////////////

    // Registered done, else any new access starts waiting
    always_comb begin
        if (state_q == DONE) begin
            state = DONE;
        end else if (dv) begin
            state = WAIT;
        end else begin
            state = IDLE;
        end
    end

    // One wait cycle, then done, then back to idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= (state == WAIT) ? DONE : IDLE;
        end
    end

    assign hold  = (state == WAIT);
    assign rdata = rdata_q;
    assign error = 1'b0;

    ////////////////////
    // Array access
    ////////////////////

    // Read captured at the wait edge, write at the completing edge
    always_ff @(posedge clk) begin
        if (state == WAIT) begin
            rdata_q <= mem[idx];
        end
        if (state == DONE && write) begin
            mem[idx] <= strb_merge(mem[idx], wdata, wstrb);
        end
    end

    // Stall only for a live request
    a_hold_needs_dv: assert property (@(posedge clk) disable iff (!rst_n)
        hold |-> dv);

endmodule

`default_nettype wire

//--- src/mci_sub_decode.sv
`default_nettype none
`include "mci_settings.svh"

module mci_sub_decode #(
    parameter int SRAM_SIZE_KB = `MCI_SRAM_SIZE_KB_DEF
) (
    // Requester side
    input  logic                dv,
    input  mci_pkg::addr_t      addr,
    input  mci_pkg::data_t      wdata,
    input  mci_pkg::strb_t      wstrb,
    input  logic                write,
    input  mci_pkg::user_t      user,
    output mci_pkg::data_t      rdata,
    output logic                hold,
    output logic                error,

    // Register block
    output logic                reg_dv,
    input  mci_pkg::data_t      reg_rdata,
    input  logic                reg_hold,
    input  logic                reg_error,

    // SRAM
    output logic                sram_dv,
    input  mci_pkg::data_t      sram_rdata,
    input  logic                sram_hold,
    input  logic                sram_error,

    // Mailbox 0
    output logic                mbox0_dv,
    input  mci_pkg::data_t      mbox0_rdata,
    input  logic                mbox0_hold,
    input  logic                mbox0_error,

    // Mailbox 1
    output logic                mbox1_dv,
    input  mci_pkg::data_t      mbox1_rdata,
    input  logic                mbox1_hold,
    input  logic                mbox1_error,

    // Request fields seen by every target
    output mci_pkg::addr_t      tgt_addr,
    output mci_pkg::data_t      tgt_wdata,
    output mci_pkg::strb_t      tgt_wstrb,
    output logic                tgt_write,

    // Mailbox valid-user lists
    input  mci_pkg::user_list_t mbox0_users,
    input  mci_pkg::user_list_t mbox1_users,

    // Privileged user straps
    input  mci_pkg::user_t      strap_lsu_user,
    input  mci_pkg::user_t      strap_ifu_user,
    input  mci_pkg::user_t      strap_cptra_user,
    input  mci_pkg::user_t      strap_debug_user,

    // Privileged request flags
    output logic                lsu_req,
    output logic                ifu_req,
    output logic                mcu_req,
    output logic                debug_req,
    output logic                cptra_req
);
    import mci_pkg::*;

    // Inclusive region limits over the full address
    localparam addr_t REG_LO   = `MCI_REG_BASE;
    localparam addr_t REG_HI   = `MCI_REG_BASE + `MCI_REG_SIZE - 1;
    localparam addr_t MBOX0_LO = `MCI_MBOX0_BASE;
    localparam addr_t MBOX0_HI = `MCI_MBOX0_BASE + `MCI_MBOX0_SIZE - 1;
    localparam addr_t MBOX1_LO = `MCI_MBOX1_BASE;
    localparam addr_t MBOX1_HI = `MCI_MBOX1_BASE + `MCI_MBOX1_SIZE - 1;
    localparam addr_t SRAM_LO  = `MCI_SRAM_BASE;
    localparam addr_t SRAM_HI  = `MCI_SRAM_BASE + SRAM_SIZE_KB * 1024 - 1;

    logic in_reg;
    logic in_sram;
    logic in_mbox0;
    logic in_mbox1;
    logic full_strb;
    logic mbox0_ok;
    logic mbox1_ok;
    logic dbg_match;
    logic miss;

    // User found in any entry of a list
    function automatic logic in_list(input user_list_t list, input user_t u);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `MCI_MBOX_USER_N; i++) begin
            hit |= (list[i] == u);
        end
        return hit;
    endfunction

    ////////////////////
    // Region decode
    ////////////////////

    assign in_reg   = addr inside {[REG_LO:REG_HI]};
    assign in_sram  = addr inside {[SRAM_LO:SRAM_HI]};
    assign in_mbox0 = addr inside {[MBOX0_LO:MBOX0_HI]};
    assign in_mbox1 = addr inside {[MBOX1_LO:MBOX1_HI]};

    // Reads pass, writes need every byte lane
    assign full_strb = ~write | (&wstrb);

    // Listed user, default user, MCU or debug
    assign mbox0_ok = in_list(mbox0_users, user) | (user == `MCI_DEF_MBOX_USER)
                    | mcu_req | debug_req;
    assign mbox1_ok = in_list(mbox1_users, user) | (user == `MCI_DEF_MBOX_USER)
                    | mcu_req | debug_req;

    assign reg_dv   = dv & in_reg;
    assign sram_dv  = dv & in_sram;
    assign mbox0_dv = dv & in_mbox0 & mbox0_ok & full_strb;
    assign mbox1_dv = dv & in_mbox1 & mbox1_ok & full_strb;

    // Same request fields to all targets
    assign tgt_addr  = addr;
    assign tgt_wdata = wdata;
    assign tgt_wstrb = wstrb;
    assign tgt_write = write;

    ////////////////////
    // Privileged users
    ////////////////////

    assign lsu_req   = dv & (user == strap_lsu_user);
    assign ifu_req   = dv & (user == strap_ifu_user);
    assign mcu_req   = lsu_req | ifu_req;
    assign cptra_req = dv & (user == strap_cptra_user);

    // Debug strap of zero disables, all ones forces every request
    assign dbg_match = (|strap_debug_user) & (user == strap_debug_user);
    assign debug_req = dv & ((&strap_debug_user) | dbg_match);

    ////////////////////
    // Response return
    ////////////////////

    // Request that reached no target
    assign miss = dv & ~(reg_dv | sram_dv | mbox0_dv | mbox1_dv);

    assign rdata = reg_dv   ? reg_rdata   :
                   sram_dv  ? sram_rdata  :
                   mbox0_dv ? mbox0_rdata :
                   mbox1_dv ? mbox1_rdata :
                   '0;

    assign hold  = (reg_dv & reg_hold) | (sram_dv & sram_hold)
                 | (mbox0_dv & mbox0_hold) | (mbox1_dv & mbox1_hold);

    assign error = (reg_dv & reg_error) | (sram_dv & sram_error)
                 | (mbox0_dv & mbox0_error) | (mbox1_dv & mbox1_error) | miss;

    // Regions of the map must never overlap
    always_comb begin
        a_one_target: assert final ($onehot0({reg_dv, sram_dv, mbox0_dv, mbox1_dv}))
            else $error("decode selected more than one target");
    end

endmodule

`default_nettype wire

//--- src/mci_top.sv
`default_nettype none
`include "mci_settings.svh"

module mci_top #(
    parameter int SRAM_SIZE_KB = `MCI_SRAM_SIZE_KB_DEF
) (
    input  logic           clk,
    input  logic           rst_n,

    // Requester side
    input  logic           dv,
    input  mci_pkg::addr_t addr,
    input  mci_pkg::data_t wdata,
    input  mci_pkg::strb_t wstrb,
    input  logic           write,
    input  mci_pkg::user_t user,
    output mci_pkg::data_t rdata,
    output logic           hold,
    output logic           error,

    // Privileged user straps
    input  mci_pkg::user_t strap_lsu_user,
    input  mci_pkg::user_t strap_ifu_user,
    input  mci_pkg::user_t strap_cptra_user,
    input  mci_pkg::user_t strap_debug_user,

    // Privileged request flags
    output logic           lsu_req,
    output logic           ifu_req,
    output logic           mcu_req,
    output logic           debug_req,
    output logic           cptra_req
);
    import mci_pkg::*;

    // Shared request fields
    addr_t      tgt_addr;
    data_t      tgt_wdata;
    strb_t      tgt_wstrb;
    logic       tgt_write;

    // Per target strobe and response
    logic       reg_dv;
    data_t      reg_rdata;
    logic       reg_hold;
    logic       reg_error;
    logic       sram_dv;
    data_t      sram_rdata;
    logic       sram_hold;
    logic       sram_error;
    logic       mbox0_dv;
    data_t      mbox0_rdata;
    logic       mbox0_hold;
    logic       mbox0_error;
    logic       mbox1_dv;
    data_t      mbox1_rdata;
    logic       mbox1_hold;
    logic       mbox1_error;

    // Lists from the register block
    user_list_t mbox0_users;
    user_list_t mbox1_users;

    ////////////////////
    // Decoder
    ////////////////////

    mci_sub_decode #(
        .SRAM_SIZE_KB (SRAM_SIZE_KB)
    ) u_decode (
        .dv               (dv),
        .addr             (addr),
        .wdata            (wdata),
        .wstrb            (wstrb),
        .write            (write),
        .user             (user),
        .rdata            (rdata),
        .hold             (hold),
        .error            (error),
        .reg_dv           (reg_dv),
        .reg_rdata        (reg_rdata),
        .reg_hold         (reg_hold),
        .reg_error        (reg_error),
        .sram_dv          (sram_dv),
        .sram_rdata       (sram_rdata),
        .sram_hold        (sram_hold),
        .sram_error       (sram_error),
        .mbox0_dv         (mbox0_dv),
        .mbox0_rdata      (mbox0_rdata),
        .mbox0_hold       (mbox0_hold),
        .mbox0_error      (mbox0_error),
        .mbox1_dv         (mbox1_dv),
        .mbox1_rdata      (mbox1_rdata),
        .mbox1_hold       (mbox1_hold),
        .mbox1_error      (mbox1_error),
        .tgt_addr         (tgt_addr),
        .tgt_wdata        (tgt_wdata),
        .tgt_wstrb        (tgt_wstrb),
        .tgt_write        (tgt_write),
        .mbox0_users      (mbox0_users),
        .mbox1_users      (mbox1_users),
        .strap_lsu_user   (strap_lsu_user),
        .strap_ifu_user   (strap_ifu_user),
        .strap_cptra_user (strap_cptra_user),
        .strap_debug_user (strap_debug_user),
        .lsu_req          (lsu_req),
        .ifu_req          (ifu_req),
        .mcu_req          (mcu_req),
        .debug_req        (debug_req),
        .cptra_req        (cptra_req)
    );

    ////////////////////
    // Targets
    ////////////////////

    // MCU request grants list write privilege
    mci_reg_block u_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .dv          (reg_dv),
        .addr        (tgt_addr),
        .wdata       (tgt_wdata),
        .wstrb       (tgt_wstrb),
        .write       (tgt_write),
        .priv        (mcu_req),
        .rdata       (reg_rdata),
        .hold        (reg_hold),
        .error       (reg_error),
        .mbox0_users (mbox0_users),
        .mbox1_users (mbox1_users)
    );

    mci_sram #(
        .SRAM_SIZE_KB (SRAM_SIZE_KB)
    ) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .dv    (sram_dv),
        .addr  (tgt_addr),
        .wdata (tgt_wdata),
        .wstrb (tgt_wstrb),
        .write (tgt_write),
        .rdata (sram_rdata),
        .hold  (sram_hold),
        .error (sram_error)
    );

    mci_mbox_mem u_mbox0 (
        .clk   (clk),
        .rst_n (rst_n),
        .dv    (mbox0_dv),
        .addr  (tgt_addr),
        .wdata (tgt_wdata),
        .wstrb (tgt_wstrb),
        .write (tgt_write),
        .rdata (mbox0_rdata),
        .hold  (mbox0_hold),
        .error (mbox0_error)
    );

    mci_mbox_mem u_mbox1 (
        .clk   (clk),
        .rst_n (rst_n),
        .dv    (mbox1_dv),
        .addr  (tgt_addr),
        .wdata (tgt_wdata),
        .wstrb (tgt_wstrb),
        .write (tgt_write),
        .rdata (mbox1_rdata),
        .hold  (mbox1_hold),
        .error (mbox1_error)
    );

endmodule

`default_nettype wire

//--- tb/mci_testdata.txt
# op user     addr     wdata    strb rdata    err flags
# flags are lsu ifu mcu debug cptra, bit 4 down to bit 0
W FFFFFFFF 00000000 A5A5A5A5 F 00000000 0 00
W FFFFFFFF 00000000 11223344 5 00000000 0 00
R FFFFFFFF 00000000 00000000 0 A522A544 0 00
W 00000055 00004000 DEADBEEF F 00000000 0 00
W 00000055 00004010 01234567 F 00000000 0 00
W 00000055 000043FC CAFEF00D F 00000000 0 00
R 00000055 00004000 00000000 0 DEADBEEF 0 00
R 00000055 00004010 00000000 0 01234567 0 00
R 00000055 000043FC 00000000 0 CAFEF00D 0 00
W 00000055 00004010 FFFFFFFF 2 00000000 0 00
R 00000055 00004010 00000000 0 0123FF67 0 00
R FFFFFFFF 00000800 00000000 0 00000000 1 00
R FFFFFFFF 00001100 00000000 0 00000000 1 00
W FFFFFFFF 00003000 12345678 F 00000000 1 00
R FFFFFFFF 00004400 00000000 0 00000000 1 00
R FFFFFFFF 10001000 00000000 0 00000000 1 00
W 00000055 00001008 12345678 F 00000000 1 00
R FFFFFFFF 00001008 00000000 0 00000000 0 00
W 00000011 00000010 00000055 F 00000000 0 14
R 00000011 00000010 00000000 0 00000055 0 14
W 00000055 00001008 12345678 F 00000000 0 00
R FFFFFFFF 00001008 00000000 0 12345678 0 00
W 00000055 00002008 12345678 F 00000000 1 00
R FFFFFFFF 00002008 00000000 0 00000000 0 00
W 00000055 00001008 AAAAAAAA 3 00000000 1 00
R 00000055 00001008 00000000 0 12345678 0 00
R 00000055 00001008 00000000 5 12345678 0 00
W 00000055 00000014 00000066 F 00000000 1 00
W 00000033 00000018 00000066 F 00000000 1 01
R FFFFFFFF 00000014 00000000 0 FFFFFFFF 0 00
R FFFFFFFF 00000008 00000000 0 00000000 1 00
W 00000011 00000044 00000066 F 00000000 1 14
R 00000011 00000000 00000000 0 A522A544 0 14
R 00000012 00000000 00000000 0 A522A544 0 0C
R 00000033 00000000 00000000 0 A522A544 0 01
R 00000044 00000000 00000000 0 A522A544 0 02
W 00000044 00002010 0BADC0DE F 00000000 0 02
R 00000044 00002010 00000000 0 0BADC0DE 0 02
W 00000012 00000030 00000077 F 00000000 0 0C
R FFFFFFFF 00000030 00000000 0 00000077 0 00
W 00000077 00002000 00C0FFEE F 00000000 0 00
R 00000077 00002000 00000000 0 00C0FFEE 0 00
R 00000066 00000000 00000000 0 A522A544 0 00

//--- tb/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period, 2 ns per half cycle
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/tb_mci_top.sv
`default_nettype none
`include "mci_settings.svh"

module tb_mci_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    SRAM_KB      = 1;
    localparam int    RESET_CYCLES = 8;
    localparam int    MAX_VEC      = 64;
    localparam string DATA_FILE    = "tb/mci_testdata.txt";

    // Straps for the privileged users
    localparam logic [31:0] LSU_USER   = 32'h0000_0011;
    localparam logic [31:0] IFU_USER   = 32'h0000_0012;
    localparam logic [31:0] CPTRA_USER = 32'h0000_0033;
    localparam logic [31:0] DEBUG_USER = 32'h0000_0044;

    // SRAM window, one wait state expected inside it
    localparam logic [31:0] SRAM_LO = `MCI_SRAM_BASE;
    localparam logic [31:0] SRAM_HI = `MCI_SRAM_BASE + SRAM_KB * 1024 - 1;

    logic        clk;
    logic        rst_n;
    logic        dv;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        write;
    logic [31:0] user;
    logic [31:0] rdata;
    logic        hold;
    logic        error;
    logic        lsu_req;
    logic        ifu_req;
    logic        mcu_req;
    logic        debug_req;
    logic        cptra_req;
    logic [4:0]  flags;

    // Vector storage
    logic        vec_write [MAX_VEC];
    logic [31:0] vec_user  [MAX_VEC];
    logic [31:0] vec_addr  [MAX_VEC];
    logic [31:0] vec_wdata [MAX_VEC];
    logic [3:0]  vec_strb  [MAX_VEC];
    logic [31:0] vec_rdata [MAX_VEC];
    logic        vec_err   [MAX_VEC];
    logic [4:0]  vec_flags [MAX_VEC];
    int          n_vec  = 0;
    int          errors = 0;
    int          checks = 0;
    bit          loaded = 1'b0;

    // Flag bits in the order of the data file
    assign flags = {lsu_req, ifu_req, mcu_req, debug_req, cptra_req};

    tb_clk_gen #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mci_top #(
        .SRAM_SIZE_KB (SRAM_KB)
    ) uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .dv               (dv),
        .addr             (addr),
        .wdata            (wdata),
        .wstrb            (wstrb),
        .write            (write),
        .user             (user),
        .rdata            (rdata),
        .hold             (hold),
        .error            (error),
        .strap_lsu_user   (LSU_USER),
        .strap_ifu_user   (IFU_USER),
        .strap_cptra_user (CPTRA_USER),
        .strap_debug_user (DEBUG_USER),
        .lsu_req          (lsu_req),
        .ifu_req          (ifu_req),
        .mcu_req          (mcu_req),
        .debug_req        (debug_req),
        .cptra_req        (cptra_req)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic bit is_sram_addr(input logic [31:0] a);
        return (a >= SRAM_LO) && (a <= SRAM_HI);
    endfunction

    task automatic check_value(input string name, input int vec, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s vector %0d exp=%h got=%h", name, vec, exp, got);
        end
    endtask

    // Drop the rest of a comment line
    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       tok;
        logic [31:0] f_user;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [3:0]  f_strb;
        logic [31:0] f_rdata;
        logic        f_err;
        logic [4:0]  f_flags;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: cannot open the test data file %s", DATA_FILE);
            return;
        end
        while (1) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            // A leading # marks a comment line
            if (tok.getc(0) == 8'h23) begin
                skip_line(fd);
                continue;
            end
            code = $fscanf(fd, "%h %h %h %h %h %h %h",
                           f_user, f_addr, f_wdata, f_strb, f_rdata, f_err, f_flags);
            if (code != 7) begin
                errors++;
                $display("ERROR: malformed test data line after vector %0d", n_vec);
                break;
            end
            if (tok != "W" && tok != "R") begin
                errors++;
                $display("ERROR: unknown operation %s in the test data", tok);
                continue;
            end
            if (n_vec >= MAX_VEC) begin
                errors++;
                $display("ERROR: more than %0d vectors in the test data", MAX_VEC);
                break;
            end
            vec_write[n_vec] = (tok == "W");
            vec_user[n_vec]  = f_user;
            vec_addr[n_vec]  = f_addr;
            vec_wdata[n_vec] = f_wdata;
            vec_strb[n_vec]  = f_strb;
            vec_rdata[n_vec] = f_rdata;
            vec_err[n_vec]   = f_err;
            vec_flags[n_vec] = f_flags;
            n_vec++;
        end
        $fclose(fd);
    endtask

    // Called right after a rising edge
    task automatic drive_request(input int i);
        dv    <= 1'b1;
        write <= vec_write[i];
        user  <= vec_user[i];
        addr  <= vec_addr[i];
        wdata <= vec_wdata[i];
        wstrb <= vec_strb[i];
    endtask

    // Drive one vector, count hold cycles at falling edges, check before completion
    task automatic run_vector(input int i);
        int hold_cycles;
        int exp_hold;
        hold_cycles = 0;
        exp_hold    = is_sram_addr(vec_addr[i]) ? 1 : 0;
        @(posedge clk);
        drive_request(i);
        @(negedge clk);
        while (hold === 1'b1) begin
            hold_cycles++;
            @(negedge clk);
        end
        if (!vec_write[i]) begin
            check_value("rdata", i, vec_rdata[i], rdata);
        end
        check_value("error", i, 32'(vec_err[i]), 32'(error));
        check_value("flags", i, 32'(vec_flags[i]), 32'(flags));
        check_value("hold_cycles", i, 32'(exp_hold), 32'(hold_cycles));
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        dv    <= 1'b0;
        write <= 1'b0;
        user  <= '0;
        addr  <= '0;
        wdata <= '0;
        wstrb <= '0;
        load_vectors();
        if (n_vec == 0 && errors == 0) begin
            errors++;
            $display("ERROR: the test data holds no vectors");
        end
        loaded = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge clk);
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
        end
        // Completing edge of the last vector, then idle
        @(posedge clk);
        dv    <= 1'b0;
        write <= 1'b0;
        @(negedge clk);
        check_value("idle_flags", n_vec, 32'h0, 32'(flags));
        check_value("idle_hold", n_vec, 32'h0, 32'(hold));
        check_value("idle_error", n_vec, 32'h0, 32'(error));
        $display("Vectors: %0d, checks: %0d, errors: %0d", n_vec, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog, 20 cycles per vector plus reset and the idle tail
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + 20 * (n_vec + 1)) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d cycles",
                 RESET_CYCLES + 20 * (n_vec + 1));
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
